// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module tb_rv_multicycle -f project.f -o sim
	./obj_dir/sim

clean:
	rm -rf obj_dir

// ==== alu.sv ====
`timescale 1ns/100ps
`include "rv_config.svh"

module alu (
    input  logic [`RV_XLEN-1:0]   a_i,
    input  logic [`RV_XLEN-1:0]   b_i,
    input  rv_ctrl_pkg::alu_ctl_e alu_ctl_i,
    output logic [`RV_XLEN-1:0]   result_o,
    output logic                  zero_o
);

    logic slt;

    assign slt = $signed(a_i) < $signed(b_i);

    always_comb begin
        case (alu_ctl_i)
            rv_ctrl_pkg::ALU_ADD: result_o = a_i + b_i;
            rv_ctrl_pkg::ALU_SUB: result_o = a_i - b_i;
            rv_ctrl_pkg::ALU_AND: result_o = a_i & b_i;
            rv_ctrl_pkg::ALU_OR:  result_o = a_i | b_i;
            rv_ctrl_pkg::ALU_SLT: result_o = {{(`RV_XLEN-1){1'b0}}, slt};
            default:              result_o = '0;
        endcase
    end

    // Used by beq after a subtract
    assign zero_o = (result_o == '0);

endmodule

// ==== control_fsm.sv ====
`timescale 1ns/100ps

module control_fsm (
    input  logic                     clk_i,
    input  logic                     reset_i,
    input  rv_isa_pkg::opcode_e      op_i,
    input  logic                     zero_i,
    output logic                     pc_write_o,
    output logic                     reg_write_o,
    output logic                     mem_write_o,
    output logic                     ir_write_o,
    output rv_ctrl_pkg::result_src_e result_src_o,
    output rv_ctrl_pkg::alu_src_a_e  alu_src_a_o,
    output rv_ctrl_pkg::alu_src_b_e  alu_src_b_o,
    output logic                     adr_src_o,
    output rv_ctrl_pkg::alu_op_e     alu_op_o
);

    typedef enum logic [3:0] {
        FETCH, DECODE, MEM_ADR, MEM_READ, MEM_WB, MEM_WRITE,
        EXECUTE_R, ALU_WB, EXECUTE_I, JAL, BEQ
    } state_e;

    state_e state_q;
    state_e state_d;
    logic   pc_update;
    logic   branch;

    always_comb begin
        state_d = state_q;
        case (state_q)
            FETCH: state_d = DECODE;
            DECODE: begin
                case (op_i)
                    rv_isa_pkg::LOAD,
                    rv_isa_pkg::STORE:  state_d = MEM_ADR;
                    rv_isa_pkg::OP:     state_d = EXECUTE_R;
                    rv_isa_pkg::OP_IMM: state_d = EXECUTE_I;
                    rv_isa_pkg::JAL:    state_d = JAL;
                    rv_isa_pkg::BRANCH: state_d = BEQ;
                    default:            state_d = DECODE; // Unsupported, hang here
                endcase
            end
            MEM_ADR: begin
                if (op_i == rv_isa_pkg::LOAD) state_d = MEM_READ;
                else if (op_i == rv_isa_pkg::STORE) state_d = MEM_WRITE;
            end
            MEM_READ:  state_d = MEM_WB;
            EXECUTE_R,
            EXECUTE_I,
            JAL:       state_d = ALU_WB;
            MEM_WB,
            MEM_WRITE,
            ALU_WB,
            BEQ:       state_d = FETCH;
            default:   state_d = FETCH;
        endcase
    end

    // Moore outputs per state
    always_comb begin
        pc_update    = 1'b0;
        branch       = 1'b0;
        reg_write_o  = 1'b0;
        mem_write_o  = 1'b0;
        ir_write_o   = 1'b0;
        adr_src_o    = 1'b0;
        result_src_o = rv_ctrl_pkg::ALU_OUT;
        alu_src_a_o  = rv_ctrl_pkg::SRC_PC;
        alu_src_b_o  = rv_ctrl_pkg::SRC_REG_B;
        alu_op_o     = rv_ctrl_pkg::OP_ADD;
        case (state_q)
            FETCH: begin
                ir_write_o   = 1'b1;
                alu_src_b_o  = rv_ctrl_pkg::SRC_FOUR; // PC + 4
                result_src_o = rv_ctrl_pkg::ALU_RESULT;
                pc_update    = 1'b1;
            end
            DECODE: begin // Branch/jump target into ALU output reg
                alu_src_a_o = rv_ctrl_pkg::SRC_OLD_PC;
                alu_src_b_o = rv_ctrl_pkg::SRC_IMM;
            end
            MEM_ADR: begin
                alu_src_a_o = rv_ctrl_pkg::SRC_REG_A;
                alu_src_b_o = rv_ctrl_pkg::SRC_IMM;
            end
            MEM_READ: adr_src_o = 1'b1;
            MEM_WB: begin
                result_src_o = rv_ctrl_pkg::MEM_DATA;
                reg_write_o  = 1'b1;
            end
            MEM_WRITE: begin
                adr_src_o   = 1'b1;
                mem_write_o = 1'b1;
            end
            EXECUTE_R: begin
                alu_src_a_o = rv_ctrl_pkg::SRC_REG_A;
                alu_op_o    = rv_ctrl_pkg::OP_FUNCT;
            end
            ALU_WB: reg_write_o = 1'b1;
            EXECUTE_I: begin
                alu_src_a_o = rv_ctrl_pkg::SRC_REG_A;
                alu_src_b_o = rv_ctrl_pkg::SRC_IMM;
                alu_op_o    = rv_ctrl_pkg::OP_FUNCT;
            end
            JAL: begin
                alu_src_a_o = rv_ctrl_pkg::SRC_OLD_PC; // Link value
                alu_src_b_o = rv_ctrl_pkg::SRC_FOUR;
                pc_update   = 1'b1;                    // Target from DECODE
            end
            BEQ: begin
                alu_src_a_o = rv_ctrl_pkg::SRC_REG_A;
                alu_op_o    = rv_ctrl_pkg::OP_SUB;
                branch      = 1'b1;
            end
            default: ;
        endcase
    end

    assign pc_write_o = pc_update || (branch && zero_i);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= FETCH;
        end else begin
            state_q <= state_d;
        end
    end

    a_no_write_clash: assert property (@(posedge clk_i) disable iff (reset_i)
        !(mem_write_o && reg_write_o));

    a_decode_target: assert property (@(posedge clk_i) disable iff (reset_i)
        state_q == DECODE |=> state_q inside {DECODE, MEM_ADR, EXECUTE_R, EXECUTE_I, JAL, BEQ});

endmodule

// ==== control_unit.sv ====
`timescale 1ns/100ps

module control_unit (
    input  logic                     clk_i,
    input  logic                     reset_i,
    input  rv_isa_pkg::instr_u       instr_i,
    input  logic                     zero_i,
    output logic                     pc_write_o,
    output logic                     reg_write_o,
    output logic                     mem_write_o,
    output logic                     ir_write_o,
    output rv_ctrl_pkg::result_src_e result_src_o,
    output rv_ctrl_pkg::alu_src_a_e  alu_src_a_o,
    output rv_ctrl_pkg::alu_src_b_e  alu_src_b_o,
    output logic                     adr_src_o,
    output rv_ctrl_pkg::imm_src_e    imm_src_o,
    output rv_ctrl_pkg::alu_ctl_e    alu_ctl_o
);

    rv_ctrl_pkg::alu_op_e alu_op;
    logic [6:0]           op_bits;
    logic                 r_sub; // R-type with funct7[5] set

    control_fsm fsm0 (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .op_i         (instr_i.r.opcode),
        .zero_i       (zero_i),
        .pc_write_o   (pc_write_o),
        .reg_write_o  (reg_write_o),
        .mem_write_o  (mem_write_o),
        .ir_write_o   (ir_write_o),
        .result_src_o (result_src_o),
        .alu_src_a_o  (alu_src_a_o),
        .alu_src_b_o  (alu_src_b_o),
        .adr_src_o    (adr_src_o),
        .alu_op_o     (alu_op)
    );

    assign op_bits = instr_i.r.opcode;
    assign r_sub   = op_bits[5] && instr_i.r.funct7[5];

    always_comb begin
        case (instr_i.r.opcode)
            rv_isa_pkg::STORE:  imm_src_o = rv_ctrl_pkg::IMM_S;
            rv_isa_pkg::BRANCH: imm_src_o = rv_ctrl_pkg::IMM_B;
            rv_isa_pkg::JAL:    imm_src_o = rv_ctrl_pkg::IMM_J;
            default:            imm_src_o = rv_ctrl_pkg::IMM_I; // lw, I-type
        endcase
    end

    always_comb begin
        alu_ctl_o = rv_ctrl_pkg::ALU_ADD;
        if (alu_op == rv_ctrl_pkg::OP_SUB) begin
            alu_ctl_o = rv_ctrl_pkg::ALU_SUB;
        end else if (alu_op == rv_ctrl_pkg::OP_FUNCT) begin
            case (instr_i.r.funct3)
                3'b000:  alu_ctl_o = r_sub ? rv_ctrl_pkg::ALU_SUB : rv_ctrl_pkg::ALU_ADD;
                3'b010:  alu_ctl_o = rv_ctrl_pkg::ALU_SLT;
                3'b110:  alu_ctl_o = rv_ctrl_pkg::ALU_OR;
                3'b111:  alu_ctl_o = rv_ctrl_pkg::ALU_AND;
                default: alu_ctl_o = rv_ctrl_pkg::ALU_ADD;
            endcase
        end
    end

endmodule

// ==== datapath.sv ====
`timescale 1ns/100ps
`include "rv_config.svh"

module datapath (
    input  logic                     clk_i,
    input  logic                     reset_i,
    input  logic                     pc_write_i,
    input  logic                     ir_write_i,
    input  logic                     reg_write_i,
    input  logic                     adr_src_i,
    input  rv_ctrl_pkg::result_src_e result_src_i,
    input  rv_ctrl_pkg::alu_src_a_e  alu_src_a_i,
    input  rv_ctrl_pkg::alu_src_b_e  alu_src_b_i,
    input  rv_ctrl_pkg::imm_src_e    imm_src_i,
    input  rv_ctrl_pkg::alu_ctl_e    alu_ctl_i,
    input  logic [`RV_XLEN-1:0]      mem_rdata_i,
    output rv_isa_pkg::instr_u       instr_o,
    output logic                     zero_o,
    output logic [`RV_XLEN-1:0]      mem_adr_o,
    output logic [`RV_XLEN-1:0]      mem_wdata_o
);

    logic [`RV_XLEN-1:0] pc_q;
    logic [`RV_XLEN-1:0] old_pc_q;
    rv_isa_pkg::instr_u  instr_q;
    logic [`RV_XLEN-1:0] data_q;
    logic [`RV_XLEN-1:0] a_q;
    logic [`RV_XLEN-1:0] b_q;
    logic [`RV_XLEN-1:0] alu_out_q;
    logic [`RV_XLEN-1:0] rd1;
    logic [`RV_XLEN-1:0] rd2;
    logic [`RV_XLEN-1:0] imm_ext;
    logic [`RV_XLEN-1:0] src_a;
    logic [`RV_XLEN-1:0] src_b;
    logic [`RV_XLEN-1:0] alu_result;
    logic [`RV_XLEN-1:0] result;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pc_q <= `RV_RESET_PC;
        end else if (pc_write_i) begin
            pc_q <= result;
        end
    end

    always_ff @(posedge clk_i) begin
        if (ir_write_i) begin
            old_pc_q <= pc_q;
            instr_q  <= mem_rdata_i;
        end
        data_q    <= mem_rdata_i;
        a_q       <= rd1;
        b_q       <= rd2;
        alu_out_q <= alu_result;
    end

    regfile rf0 (
        .clk_i (clk_i),
        .a1_i  (instr_q.r.rs1),
        .a2_i  (instr_q.r.rs2),
        .a3_i  (instr_q.r.rd),
        .wd3_i (result),
        .we3_i (reg_write_i),
        .rd1_o (rd1),
        .rd2_o (rd2)
    );

    // Sign extension by format
    always_comb begin
        case (imm_src_i)
            rv_ctrl_pkg::IMM_S: imm_ext = {{(`RV_XLEN-12){instr_q.s.imm_11_5[6]}},
                                           instr_q.s.imm_11_5, instr_q.s.imm_4_0};
            rv_ctrl_pkg::IMM_B: imm_ext = {{(`RV_XLEN-13){instr_q.b.imm_12}}, instr_q.b.imm_12,
                                           instr_q.b.imm_11, instr_q.b.imm_10_5,
                                           instr_q.b.imm_4_1, 1'b0};
            rv_ctrl_pkg::IMM_J: imm_ext = {{(`RV_XLEN-21){instr_q.j.imm_20}}, instr_q.j.imm_20,
                                           instr_q.j.imm_19_12, instr_q.j.imm_11,
                                           instr_q.j.imm_10_1, 1'b0};
            default:            imm_ext = {{(`RV_XLEN-12){instr_q.i.imm_11_0[11]}},
                                           instr_q.i.imm_11_0};
        endcase
    end

    always_comb begin
        case (alu_src_a_i)
            rv_ctrl_pkg::SRC_OLD_PC: src_a = old_pc_q;
            rv_ctrl_pkg::SRC_REG_A:  src_a = a_q;
            default:                 src_a = pc_q;
        endcase
        case (alu_src_b_i)
            rv_ctrl_pkg::SRC_IMM:  src_b = imm_ext;
            rv_ctrl_pkg::SRC_FOUR: src_b = `RV_XLEN'd4;
            default:               src_b = b_q;
        endcase
        case (result_src_i)
            rv_ctrl_pkg::MEM_DATA:   result = data_q;
            rv_ctrl_pkg::ALU_RESULT: result = alu_result;
            default:                 result = alu_out_q;
        endcase
    end

    alu alu0 (
        .a_i       (src_a),
        .b_i       (src_b),
        .alu_ctl_i (alu_ctl_i),
        .result_o  (alu_result),
        .zero_o    (zero_o)
    );

    assign mem_adr_o   = adr_src_i ? result : pc_q; // Data address via ALU output reg
    assign mem_wdata_o = b_q;
    assign instr_o     = instr_q;

    a_pc_aligned: assert property (@(posedge clk_i) disable iff (reset_i)
        pc_q[1:0] == 2'b00);

endmodule

// ==== project.f ====
+incdir+.
rv_isa_pkg.sv
rv_ctrl_pkg.sv
regfile.sv
alu.sv
control_fsm.sv
control_unit.sv
datapath.sv
rv_multicycle_top.sv
tb_rv_multicycle.sv

// ==== regfile.sv ====
`timescale 1ns/100ps
`include "rv_config.svh"

module regfile (
    input  logic                             clk_i,
    input  logic [$clog2(`RV_REG_COUNT)-1:0] a1_i,
    input  logic [$clog2(`RV_REG_COUNT)-1:0] a2_i,
    input  logic [$clog2(`RV_REG_COUNT)-1:0] a3_i,
    input  logic [`RV_XLEN-1:0]              wd3_i,
    input  logic                             we3_i,
    output logic [`RV_XLEN-1:0]              rd1_o,
    output logic [`RV_XLEN-1:0]              rd2_o
);

    logic [`RV_XLEN-1:0] regs [`RV_REG_COUNT];

    always_ff @(posedge clk_i) begin
        if (we3_i && a3_i != '0) begin // x0 stays zero
            regs[a3_i] <= wd3_i;
        end
    end

    assign rd1_o = (a1_i == '0) ? '0 : regs[a1_i];
    assign rd2_o = (a2_i == '0) ? '0 : regs[a2_i];

endmodule

// ==== rv_config.svh ====
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// Data and address width
`define RV_XLEN 32

// Architectural registers x0..x31
`define RV_REG_COUNT 32

// First fetch address after reset
`define RV_RESET_PC 32'h0000_0000

`endif

// ==== rv_ctrl_pkg.sv ====
package rv_ctrl_pkg;

    typedef enum logic [1:0] {
        ALU_OUT    = 2'b00, // Registered ALU output
        MEM_DATA   = 2'b01,
        ALU_RESULT = 2'b10  // Straight from the ALU
    } result_src_e;

    typedef enum logic [1:0] {
        SRC_PC     = 2'b00,
        SRC_OLD_PC = 2'b01,
        SRC_REG_A  = 2'b10
    } alu_src_a_e;

    typedef enum logic [1:0] {
        SRC_REG_B = 2'b00,
        SRC_IMM   = 2'b01,
        SRC_FOUR  = 2'b10
    } alu_src_b_e;

    // Operation class from the FSM, refined by the ALU decoder
    typedef enum logic [1:0] {
        OP_ADD   = 2'b00,
        OP_SUB   = 2'b01,
        OP_FUNCT = 2'b10
    } alu_op_e;

    typedef enum logic [2:0] {
        ALU_ADD = 3'b000,
        ALU_SUB = 3'b001,
        ALU_AND = 3'b010,
        ALU_OR  = 3'b011,
        ALU_SLT = 3'b101
    } alu_ctl_e;

    typedef enum logic [1:0] {
        IMM_I = 2'b00,
        IMM_S = 2'b01,
        IMM_B = 2'b10,
        IMM_J = 2'b11
    } imm_src_e;

endpackage

// ==== rv_isa_pkg.sv ====
package rv_isa_pkg;

    // Supported major opcodes only
    typedef enum logic [6:0] {
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        JAL    = 7'b1101111,
        BRANCH = 7'b1100011
    } opcode_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_e     opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        opcode_e    opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        opcode_e    opcode;
    } b_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        opcode_e    opcode;
    } j_fmt_t;

    // One instruction word, viewed per format
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        j_fmt_t j;
    } instr_u;

endpackage

// ==== rv_multicycle_top.sv ====
`timescale 1ns/100ps
`include "rv_config.svh"

module rv_multicycle_top (
    input  logic                clk_i,
    input  logic                reset_i,
    input  logic [`RV_XLEN-1:0] mem_rdata_i,
    output logic [`RV_XLEN-1:0] mem_adr_o,
    output logic [`RV_XLEN-1:0] mem_wdata_o,
    output logic                mem_we_o
);

    logic                     pc_write;
    logic                     ir_write;
    logic                     reg_write;
    logic                     adr_src;
    logic                     zero;
    rv_ctrl_pkg::result_src_e result_src;
    rv_ctrl_pkg::alu_src_a_e  alu_src_a;
    rv_ctrl_pkg::alu_src_b_e  alu_src_b;
    rv_ctrl_pkg::imm_src_e    imm_src;
    rv_ctrl_pkg::alu_ctl_e    alu_ctl;
    rv_isa_pkg::instr_u       instr;

    control_unit cu0 (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .instr_i      (instr),
        .zero_i       (zero),
        .pc_write_o   (pc_write),
        .reg_write_o  (reg_write),
        .mem_write_o  (mem_we_o),
        .ir_write_o   (ir_write),
        .result_src_o (result_src),
        .alu_src_a_o  (alu_src_a),
        .alu_src_b_o  (alu_src_b),
        .adr_src_o    (adr_src),
        .imm_src_o    (imm_src),
        .alu_ctl_o    (alu_ctl)
    );

    datapath dp0 (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .pc_write_i   (pc_write),
        .ir_write_i   (ir_write),
        .reg_write_i  (reg_write),
        .adr_src_i    (adr_src),
        .result_src_i (result_src),
        .alu_src_a_i  (alu_src_a),
        .alu_src_b_i  (alu_src_b),
        .imm_src_i    (imm_src),
        .alu_ctl_i    (alu_ctl),
        .mem_rdata_i  (mem_rdata_i),
        .instr_o      (instr),
        .zero_o       (zero),
        .mem_adr_o    (mem_adr_o),
        .mem_wdata_o  (mem_wdata_o)
    );

endmodule

// ==== tb_rv_multicycle.sv ====
`timescale 1ns/100ps
`include "rv_config.svh"

module tb_rv_multicycle;

    localparam int CLK_PERIOD   = 100;
    localparam int DRIVE_DELAY  = 1;
    localparam int RESET_CYCLES = 2;
    localparam int MEM_WORDS    = 256;      // 1 KiB test memory
    localparam int BODY_START   = 31;       // After register setup
    localparam int SIG_START    = 79;
    localparam int FINAL_IDX    = SIG_START + 32;
    localparam int PROG_LEN     = FINAL_IDX + 1;
    localparam int DATA_BASE_W  = 128;      // Byte address 0x200
    localparam int DATA_WORDS   = 64;
    localparam logic [11:0] SIG_OFFSET = 12'h100; // Signature at 0x300
    localparam logic [`RV_XLEN-1:0] FINAL_PC = `RV_XLEN'(4 * FINAL_IDX);

    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // add, sub, and, or, slt
    localparam logic [2:0] R_F3 [5] = '{3'b000, 3'b000, 3'b111, 3'b110, 3'b010};
    // addi, andi, ori, slti
    localparam logic [2:0] I_F3 [4] = '{3'b000, 3'b111, 3'b110, 3'b010};

    logic                clk_i;
    logic                reset_i;
    logic [`RV_XLEN-1:0] mem_rdata_i;
    logic [`RV_XLEN-1:0] mem_adr_o;
    logic [`RV_XLEN-1:0] mem_wdata_o;
    logic                mem_we_o;

    logic [`RV_XLEN-1:0] mem [MEM_WORDS];       // Memory seen by the DUT
    logic [`RV_XLEN-1:0] model_mem [MEM_WORDS];
    logic [`RV_XLEN-1:0] model_regs [32];
    logic [`RV_XLEN-1:0] model_pc;
    int                  seed;

    rv_multicycle_top dut0 (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .mem_rdata_i (mem_rdata_i),
        .mem_adr_o   (mem_adr_o),
        .mem_wdata_o (mem_wdata_o),
        .mem_we_o    (mem_we_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_addr(input string name, input logic [`RV_XLEN-1:0] got,
                              input logic [`RV_XLEN-1:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_word(input string name, input logic [`RV_XLEN-1:0] got,
                              input logic [`RV_XLEN-1:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_we(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    function automatic int pick_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_word(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] b_word(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] j_word(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    function automatic logic [31:0] expected_alu(input logic [2:0] f3, input logic sub,
                                                 input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return sub ? a - b : a + b;
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b110:  return a | b;
            3'b111:  return a & b;
            default: return 32'd0;
        endcase
    endfunction

    task automatic build_program();
        int         i;
        int         pos;
        int         kind;
        int         sel;
        int         span;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;

        for (i = 0; i < MEM_WORDS; i++) begin
            mem[i[7:0]] = {~16'(i), 16'(i)};
        end
        for (i = DATA_BASE_W; i < DATA_BASE_W + DATA_WORDS; i++) begin
            mem[i[7:0]] = $random(seed);
        end
        mem[0] = i_word(12'h200, 5'd0, 3'b000, 5'd31, OPC_OP_IMM); // x31 is the data base
        for (i = 1; i < BODY_START; i++) begin
            mem[i[7:0]] = i_word(12'(pick_below(4096)), 5'd0, 3'b000, 5'(i), OPC_OP_IMM);
        end
        pos = BODY_START;
        while (pos < SIG_START) begin
            rd   = 5'(pick_below(31));
            rs1  = 5'(pick_below(32));
            rs2  = 5'(pick_below(32));
            span = 1 + pick_below((SIG_START - pos < 4) ? SIG_START - pos : 4);
            kind = pick_below(10);
            if (kind inside {5, 6} && pos + 1 >= SIG_START) kind = 3; // No room for a pair
            case (kind)
                0, 1, 2: begin
                    sel = pick_below(5);
                    mem[8'(pos)] = r_word((sel == 1) ? 7'h20 : 7'h00, rs2, rs1,
                                          R_F3[sel[2:0]], rd);
                end
                3, 4: begin
                    sel = pick_below(4);
                    mem[8'(pos)] = i_word(12'(pick_below(4096)), rs1, I_F3[sel[1:0]], rd,
                                          OPC_OP_IMM);
                end
                5, 6: begin // Load, then store the loaded register
                    rd = 5'(1 + pick_below(30));
                    mem[8'(pos)] = i_word(12'(4 * pick_below(DATA_WORDS)), 5'd31, 3'b010, rd,
                                          OPC_LOAD);
                    pos++;
                    mem[8'(pos)] = s_word(12'(4 * pick_below(DATA_WORDS)), rd, 5'd31);
                end
                7: mem[8'(pos)] = s_word(12'(4 * pick_below(DATA_WORDS)), rs2, 5'd31);
                8: begin
                    if (pick_below(2) == 0) rs2 = rs1; // Force a taken branch
                    mem[8'(pos)] = b_word(13'(4 * span), rs2, rs1);
                end
                default: mem[8'(pos)] = j_word(21'(4 * span), rd);
            endcase
            pos++;
        end
        for (i = 0; i < 32; i++) begin
            mem[8'(SIG_START + i)] = s_word(SIG_OFFSET + 12'(4 * i), 5'(i), 5'd31);
        end
        mem[8'(FINAL_IDX)] = j_word(21'd0, 5'd0); // Self-loop
        for (i = 0; i < MEM_WORDS; i++) begin
            model_mem[i[7:0]] = mem[i[7:0]];
        end
    endtask

    // Combinational read for the current address
    task automatic serve_read();
        if (mem_adr_o[`RV_XLEN-1:10] == '0) mem_rdata_i = mem[mem_adr_o[9:2]];
        else mem_rdata_i = '0;
    endtask

    task automatic commit_write();
        if (mem_we_o) begin
            if (mem_adr_o[`RV_XLEN-1:10] != '0) begin
                $display("DUT stored outside the test memory at address %h", mem_adr_o);
                abort_run();
            end else begin
                mem[mem_adr_o[9:2]] = mem_wdata_o;
            end
        end
    endtask

    // One instruction in the model, checked cycle by cycle against the DUT
    task automatic run_instruction();
        logic [31:0] ins;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        logic [31:0] next_pc;
        logic [31:0] wb_val;
        logic [31:0] ld_addr;
        logic [31:0] st_addr;
        logic        wb_en;
        logic        is_store;
        int          ncyc;
        int          cyc;

        if (model_pc[31:10] != '0) begin
            $display("Model PC %h left the test memory", model_pc);
            abort_run();
        end
        ins      = model_mem[model_pc[9:2]];
        rd       = ins[11:7];
        rs1      = ins[19:15];
        rs2      = ins[24:20];
        imm_i    = {{20{ins[31]}}, ins[31:20]};
        imm_s    = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        imm_b    = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_j    = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        next_pc  = model_pc + 32'd4;
        wb_en    = 1'b1;
        is_store = 1'b0;
        wb_val   = '0;
        st_addr  = '0;
        ncyc     = 4;
        case (ins[6:0])
            OPC_LOAD: begin
                ld_addr = model_regs[rs1] + imm_i;
                wb_val  = model_mem[ld_addr[9:2]];
                ncyc    = 5;
            end
            OPC_STORE: begin
                st_addr  = model_regs[rs1] + imm_s;
                is_store = 1'b1;
                wb_en    = 1'b0;
            end
            OPC_OP:     wb_val = expected_alu(ins[14:12], ins[30], model_regs[rs1], model_regs[rs2]);
            OPC_OP_IMM: wb_val = expected_alu(ins[14:12], 1'b0, model_regs[rs1], imm_i);
            OPC_JAL: begin
                wb_val  = model_pc + 32'd4; // Link
                next_pc = model_pc + imm_j;
            end
            OPC_BRANCH: begin
                wb_en = 1'b0;
                ncyc  = 3;
                if (model_regs[rs1] == model_regs[rs2]) next_pc = model_pc + imm_b;
            end
            default: begin
                $display("Generated program holds an unsupported word %h at %h", ins, model_pc);
                abort_run();
            end
        endcase

        for (cyc = 1; cyc <= ncyc; cyc++) begin
            serve_read();
            if (cyc == 1) check_addr("mem_adr_o (fetch)", mem_adr_o, model_pc);
            check_we("mem_we_o", mem_we_o, is_store && cyc == 4);
            if (is_store && cyc == 4) begin
                check_addr("mem_adr_o (store)", mem_adr_o, st_addr);
                check_word("mem_wdata_o", mem_wdata_o, model_regs[rs2]);
            end
            commit_write();
            @(posedge clk_i);
            #(DRIVE_DELAY);
        end

        if (is_store) model_mem[st_addr[9:2]] = model_regs[rs2];
        if (wb_en && rd != 5'd0) model_regs[rd] = wb_val;
        model_pc = next_pc;
    endtask

    initial begin
        #((PROG_LEN * 5 + 20 + RESET_CYCLES) * CLK_PERIOD);
        $display("Timeout: the program never reached its final self-loop");
        abort_run();
    end

    initial begin
        int loops;
        int i;

        seed        = 32'hcadc_5009;
        reset_i     = 1'b1;
        mem_rdata_i = '0;
        for (i = 0; i < 32; i++) begin
            model_regs[i[4:0]] = '0;
        end
        model_pc = `RV_RESET_PC;
        build_program();
        repeat (RESET_CYCLES) @(posedge clk_i);
        #(DRIVE_DELAY);
        reset_i = 1'b0; // First fetch cycle is under way
        loops   = 0;
        while (loops < 2) begin
            if (model_pc == FINAL_PC) loops++; // Second pass proves the self-loop
            run_instruction();
        end
        $display("Simulation passed");
        $finish;
    end

endmodule
